// File: build.f
src/blink_pkg.sv
src/region_ctrl_if.sv
src/free_counter.sv
src/pr_controller.sv
src/persona_region.sv
src/led_driver.sv
src/led_blink_top.sv
sim/tb_clock_gen.sv
sim/led_blink_assertions.sv
sim/tb_top.sv

// File: Makefile
# Verilator build and run for the LED blinker testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0
# keep running past assertion errors so the testbench prints its summary
RUN_ARGS  ?= +verilator+error+limit+100000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_top.sv
////////////////////////////////////////////////////////////////////////////
// LED blinker testbench
// random reconfiguration rounds with back-pressure, checks live in the
// bound checker
////////////////////////////////////////////////////////////////////////////

module tb_top;
   import blink_pkg::*;

   localparam int ROUNDS    = 20;
   localparam int MAX_GAP   = 31;
   localparam int MAX_HOLD  = 7;
   // bound on one edge of the handshake
   localparam int ACK_LIMIT = 4 * FREEZE_SETTLE;
   localparam int WATCHDOG  = ROUNDS * (FREEZE_SETTLE + MAX_GAP + 20);
   // LCG constants
   localparam int unsigned LCG_MUL = 32'd1103515245;
   localparam int unsigned LCG_ADD = 32'd12345;

   logic        clock;
   logic        reset;
   logic        pr_req;
   logic [1:0]  persona_sel;
   logic        pr_ack;
   logic        led_zero_on;
   logic        led_one_on;
   logic        led_two_on;
   logic        led_three_on;
   int unsigned lcg_state = 89;
   int unsigned timeouts = 0;

   tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

   led_blink_top i_dut (
      .clock        (clock),
      .reset        (reset),
      .pr_req       (pr_req),
      .persona_sel  (persona_sel),
      .pr_ack       (pr_ack),
      .led_zero_on  (led_zero_on),
      .led_one_on   (led_one_on),
      .led_two_on   (led_two_on),
      .led_three_on (led_three_on)
   );

   bind led_blink_top led_blink_checker i_checker (
      .clock (clock), .reset (reset), .pr_req (pr_req), .persona_sel (persona_sel),
      .pr_ack (pr_ack), .led_zero_on (led_zero_on), .led_one_on (led_one_on),
      .led_two_on (led_two_on), .led_three_on (led_three_on)
   );

   // uniform draw in 0 .. range-1 from the upper state bits
   function automatic int unsigned lcg_draw(input int unsigned range);
      lcg_state = lcg_state * LCG_MUL + LCG_ADD;
      return ((lcg_state >> 16) & 32'h7fff) % range;
   endfunction

   // polls pr_ack on each rising edge until it reaches level
   task automatic wait_ack(input logic level, input string what);
      int waited;
      waited = 0;
      while (pr_ack !== level && waited < ACK_LIMIT)
      begin
         @(posedge clock);
         waited++;
      end
      if (pr_ack !== level)
      begin
         timeouts++;
         $display("handshake timeout at %0t, pr_ack did not %s", $time, what);
      end
   endtask

   // one four-phase request, then an idle gap
   task automatic run_round(input logic [1:0] code);
      int hold;
      int gap;
      hold = lcg_draw(MAX_HOLD + 1);
      gap  = lcg_draw(MAX_GAP + 1);
      pr_req      <= 1'b1;
      persona_sel <= code;
      @(posedge clock);
      wait_ack(1'b1, "rise");
      // back-pressure, request kept up past the ack
      repeat (hold) @(posedge clock);
      pr_req <= 1'b0;
      @(posedge clock);
      wait_ack(1'b0, "fall");
      repeat (gap) @(posedge clock);
   endtask

   initial
   begin
      int unsigned base;
      int unsigned failures;
      pr_req      = 1'b0;
      persona_sel = 2'd0;
      base        = lcg_draw(4);
      @(posedge clock);
      while (reset)
         @(posedge clock);
      for (int round = 0; round < ROUNDS; round++)
      begin
         // first four rounds sweep all codes from a random start
         if (round < 4)
            run_round(2'((base + round) % 4));
         else
            run_round(2'(lcg_draw(4)));
      end
      repeat (16) @(posedge clock);
      failures = i_dut.i_checker.fail_count;
      $display("closing counts: %0d assertion failures, %0d handshake timeouts",
         failures, timeouts);
      if (failures == 0 && timeouts == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // watchdog
   initial
   begin
      repeat (WATCHDOG) @(posedge clock);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
      $display("closing counts: %0d assertion failures, %0d handshake timeouts",
         i_dut.i_checker.fail_count, timeouts);
      $display("tests failed");
      $finish;
   end

endmodule

// File: sim/led_blink_assertions.sv
////////////////////////////////////////////////////////////////////////////
// LED blinker checker
// checks the top-level ports against its own reference count and
// handshake model
////////////////////////////////////////////////////////////////////////////

module led_blink_checker (
   input logic       clock,
   input logic       reset,
   input logic       pr_req,
   input logic [1:0] persona_sel,
   input logic       pr_ack,
   input logic       led_zero_on,
   input logic       led_one_on,
   input logic       led_two_on,
   input logic       led_three_on
);
   import blink_pkg::*;

   logic [COUNT_WIDTH-1:0] ref_count;
   // reference count delayed to line up with the sampled LED outputs
   logic [COUNT_WIDTH-1:0] count_d1;
   logic [COUNT_WIDTH-1:0] count_d2;
   // request accepted and ack not yet due
   logic                   busy;
   // ack phase that lasts until the requester drops pr_req
   logic                   acking;
   // cycles since the request was accepted
   int unsigned            since;
   // last valid persona requested (blink after reset)
   logic [1:0]             want;
   // expected {led_two_on, led_three_on}
   logic [1:0]             pair;
   // read by the testbench top at the end of the run
   int unsigned            fail_count = 0;

   // region LED pair of a persona code
   function automatic logic [1:0] region_pair(input logic [1:0] code,
                                              input logic [COUNT_WIDTH-1:0] c);
      case (code)
         2'd0: return {c[COUNTER_TAP], ~c[COUNTER_TAP]};
         2'd1: return {c[COUNTER_TAP + 1], c[COUNTER_TAP + 2]};
         default: return 2'b00;
      endcase
   endfunction

   assign pair = region_pair(want, count_d2);

   ////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         ref_count <= '0;
         count_d1  <= '0;
         count_d2  <= '0;
         busy      <= 1'b0;
         acking    <= 1'b0;
         since     <= 0;
         want      <= 2'd0;
      end
      else
      begin
         ref_count <= ref_count + 1'b1;
         count_d1  <= ref_count;
         count_d2  <= count_d1;
         if (!busy && !acking && pr_req)
         begin
            busy  <= 1'b1;
            since <= 1;
         end
         else if (busy)
         begin
            since <= since + 1;
            // ack shows on the next sample at FREEZE_SETTLE + 4 after accept
            if (since == FREEZE_SETTLE + 3)
            begin
               busy   <= 1'b0;
               acking <= 1'b1;
               // code 3 keeps the old persona
               if (persona_sel != 2'd3)
                  want <= persona_sel;
            end
         end
         else if (acking && !pr_req)
            acking <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // assertions
   ////////////////////////////////////////////////////////////////////////

   assert property (@(posedge clock) $fell(reset) |->
      !(pr_ack || led_zero_on || led_one_on || led_two_on || led_three_on))
   else
   begin
      fail_count++;
      $error("FAIL %0t pr_ack/led_*_on got %b expected 00000", $time,
         $sampled({pr_ack, led_zero_on, led_one_on, led_two_on, led_three_on}));
   end

   // static LEDs run two cycles behind the count with or without freeze
   assert property (@(posedge clock) disable iff (reset)
      {led_zero_on, led_one_on} == {count_d2[COUNTER_TAP], count_d2[LED_ONE_TAP]})
   else
   begin
      fail_count++;
      $error("FAIL %0t led_zero_on/led_one_on got %b expected %b", $time,
         $sampled({led_zero_on, led_one_on}),
         $sampled({count_d2[COUNTER_TAP], count_d2[LED_ONE_TAP]}));
   end

   // four-phase ack rises on time, holds under back-pressure and falls one late
   assert property (@(posedge clock) disable iff (reset) pr_ack == acking)
   else
   begin
      fail_count++;
      $error("FAIL %0t pr_ack got %b expected %b", $time,
         $sampled(pr_ack), $sampled(acking));
   end

   // region LEDs forced on while frozen
   assert property (@(posedge clock) disable iff (reset)
      (busy && since >= 2) |-> (led_two_on && led_three_on))
   else
   begin
      fail_count++;
      $error("FAIL %0t led_two_on/led_three_on got %b expected 11", $time,
         $sampled({led_two_on, led_three_on}));
   end

   assert property (@(posedge clock) disable iff (reset)
      (ref_count >= 1 && !busy) |-> ({led_two_on, led_three_on} == pair))
   else
   begin
      fail_count++;
      $error("FAIL %0t led_two_on/led_three_on got %b expected %b", $time,
         $sampled({led_two_on, led_three_on}), $sampled(pair));
   end

endmodule

// File: sim/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset
// period 4 clock, synchronous reset held for the first 16 cycles
////////////////////////////////////////////////////////////////////////////

module tb_clock_gen (
   output logic clock,
   output logic reset
);
   localparam int HALF_PERIOD  = 2;
   localparam int RESET_CYCLES = 16;

   initial
   begin
      clock = 1'b0;
      forever
      begin
         #HALF_PERIOD clock = ~clock;
      end
   end

   // released on a rising edge like any other driven input
   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;
   end

endmodule

// File: src/led_blink_top.sv
////////////////////////////////////////////////////////////////////////////
// LED blinker top level
// static counter LEDs plus a reconfigurable persona region driving the
// upper two LEDs, with a req/ack reconfiguration port
////////////////////////////////////////////////////////////////////////////

module led_blink_top (
   input  logic       clock,
   input  logic       reset,
   input  logic       pr_req,
   input  logic [1:0] persona_sel,
   output logic       pr_ack,
   output logic       led_zero_on,
   output logic       led_one_on,
   output logic       led_two_on,
   output logic       led_three_on
);
   import blink_pkg::*;

   logic [COUNT_WIDTH-1:0] count;
   logic [COUNT_WIDTH-1:0] count_d;
   logic                   led_one;
   // raw region LEDs, before the freeze override
   logic                   region_two;
   logic                   region_three;

   // controller to region link
   region_ctrl_if region_bus ();

   free_counter u_free_counter (
      .clock   (clock),
      .reset   (reset),
      .count   (count),
      .led_one (led_one)
   );

   // code 3 passes through the cast and is dropped by the region
   pr_controller u_pr_controller (
      .clock       (clock),
      .reset       (reset),
      .pr_req      (pr_req),
      .persona_sel (persona_e'(persona_sel)),
      .pr_ack      (pr_ack),
      .ctrl        (region_bus)
   );

   persona_region u_persona_region (
      .clock     (clock),
      .reset     (reset),
      .count_d   (count_d),
      .led_two   (region_two),
      .led_three (region_three),
      .region    (region_bus)
   );

   led_driver u_led_driver (
      .clock        (clock),
      .reset        (reset),
      .count        (count),
      .led_one      (led_one),
      .region_two   (region_two),
      .region_three (region_three),
      .count_d      (count_d),
      .led_zero_on  (led_zero_on),
      .led_one_on   (led_one_on),
      .led_two_on   (led_two_on),
      .led_three_on (led_three_on),
      .monitor      (region_bus)
   );

endmodule

// File: src/led_driver.sv
////////////////////////////////////////////////////////////////////////////
// LED driver
// count delay stage, freeze override and the four LED output registers
////////////////////////////////////////////////////////////////////////////

module led_driver (
   input  logic                             clock,
   input  logic                             reset,
   input  logic [blink_pkg::COUNT_WIDTH-1:0] count,
   input  logic                             led_one,
   input  logic                             region_two,
   input  logic                             region_three,
   output logic [blink_pkg::COUNT_WIDTH-1:0] count_d,
   output logic                             led_zero_on,
   output logic                             led_one_on,
   output logic                             led_two_on,
   output logic                             led_three_on,
   region_ctrl_if.monitor                   monitor
);
   import blink_pkg::*;

   ////////////////////////////////////////////////////////////////////////
   // count delay, first LED stage for the static and region paths
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      count_d <= count;
   end

   ////////////////////////////////////////////////////////////////////////
   // output registers
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         led_zero_on  <= 1'b0;
         led_one_on   <= 1'b0;
         led_two_on   <= 1'b0;
         led_three_on <= 1'b0;
      end
      else
      begin
         // static LEDs, untouched by the freeze
         led_zero_on  <= count_d[COUNTER_TAP];
         led_one_on   <= led_one;
         // region LEDs forced on while the region is frozen
         led_two_on   <= monitor.freeze ? 1'b1 : region_two;
         led_three_on <= monitor.freeze ? 1'b1 : region_three;
      end
   end

endmodule

// File: src/persona_region.sv
////////////////////////////////////////////////////////////////////////////
// persona region
// holds the active persona and forms its LED pair from the delayed count
////////////////////////////////////////////////////////////////////////////

module persona_region (
   input  logic                             clock,
   input  logic                             reset,
   input  logic [blink_pkg::COUNT_WIDTH-1:0] count_d,
   output logic                             led_two,
   output logic                             led_three,
   region_ctrl_if.region                    region
);
   import blink_pkg::*;

   // persona currently driving the LEDs
   persona_e active;
   logic     loaded_q;

   ////////////////////////////////////////////////////////////////////////
   // persona register
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         active   <= PERSONA_BLINK;
         loaded_q <= 1'b0;
      end
      else
      begin
         // answered for every strobe, valid code or not
         loaded_q <= region.load;
         if (region.load)
         begin
            case (region.persona)
               PERSONA_BLINK,
               PERSONA_CHASE,
               PERSONA_DARK:
               begin
                  active <= region.persona;
               end
               default:
               begin
                  // undefined code, old persona stays
                  active <= active;
               end
            endcase
         end
      end
   end

   assign region.loaded = loaded_q;

   ////////////////////////////////////////////////////////////////////////
   // LED patterns
   ////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      unique case (active)
         PERSONA_BLINK:
         begin
            // the pair toggles in opposite phase
            led_two   = count_d[COUNTER_TAP];
            led_three = ~count_d[COUNTER_TAP];
         end
         PERSONA_CHASE:
         begin
            led_two   = count_d[COUNTER_TAP + 1];
            led_three = count_d[COUNTER_TAP + 2];
         end
         default:
         begin
            // PERSONA_DARK
            led_two   = 1'b0;
            led_three = 1'b0;
         end
      endcase
   end

endmodule

// File: src/pr_controller.sv
////////////////////////////////////////////////////////////////////////////
// reconfiguration controller
// four-phase req/ack toward the requester, freeze, settle, load and thaw
// toward the persona region
////////////////////////////////////////////////////////////////////////////

module pr_controller (
   input  logic                clock,
   input  logic                reset,
   input  logic                pr_req,
   input  blink_pkg::persona_e persona_sel,
   output logic                pr_ack,
   region_ctrl_if.ctrl         ctrl
);
   import blink_pkg::*;

   pr_state_e               state;
   // settle down-counter, only meaningful in PR_FREEZE
   logic [SETTLE_WIDTH-1:0] settle;
   // load strobe, high for the first cycle of PR_LOAD only
   logic                    load_q;
   // code handed to the region
   persona_e                persona_q;

   ////////////////////////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state     <= PR_IDLE;
         settle    <= '0;
         load_q    <= 1'b0;
         persona_q <= PERSONA_BLINK;
      end
      else
      begin
         // strobe by default
         load_q <= 1'b0;
         unique case (state)
            PR_IDLE:
            begin
               // requester holds persona_sel stable from here on
               if (pr_req)
               begin
                  state  <= PR_FREEZE;
                  settle <= SETTLE_WIDTH'(FREEZE_SETTLE - 1);
               end
            end
            PR_FREEZE:
            begin
               // FREEZE_SETTLE cycles in this state, then load
               if (settle == '0)
               begin
                  state     <= PR_LOAD;
                  load_q    <= 1'b1;
                  persona_q <= persona_sel;
               end
               else
               begin
                  settle <= settle - 1'b1;
               end
            end
            PR_LOAD:
            begin
               // region answers one cycle after the strobe
               if (ctrl.loaded)
               begin
                  state <= PR_THAW;
               end
            end
            PR_THAW:
            begin
               state <= PR_ACK;
            end
            PR_ACK:
            begin
               // back-pressure, ack held until the requester lets go
               if (!pr_req)
               begin
                  state <= PR_IDLE;
               end
            end
            default:
            begin
               state <= PR_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // outputs, decoded from the state register
   ////////////////////////////////////////////////////////////////////////

   // freeze covers the settle time and the load, drops in PR_THAW
   assign ctrl.freeze  = (state == PR_FREEZE) || (state == PR_LOAD);
   assign ctrl.load    = load_q;
   assign ctrl.persona = persona_q;
   assign pr_ack       = (state == PR_ACK);

endmodule

// File: src/free_counter.sv
////////////////////////////////////////////////////////////////////////////
// free-running counter
// counts every cycle from zero and registers the led_one tap
////////////////////////////////////////////////////////////////////////////

module free_counter (
   input  logic                             clock,
   input  logic                             reset,
   output logic [blink_pkg::COUNT_WIDTH-1:0] count,
   output logic                             led_one
);
   import blink_pkg::*;

   ////////////////////////////////////////////////////////////////////////
   // counter
   ////////////////////////////////////////////////////////////////////////

   // wraps silently after 2^COUNT_WIDTH cycles
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         count <= '0;
      end
      else
      begin
         count <= count + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // led_one tap
   ////////////////////////////////////////////////////////////////////////

   // first of the two LED delay stages, the driver adds the second
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         led_one <= 1'b0;
      end
      else
      begin
         led_one <= count[LED_ONE_TAP];
      end
   end

endmodule

// File: src/region_ctrl_if.sv
////////////////////////////////////////////////////////////////////////////
// region control interface
// freeze, load and persona from the controller, loaded back from the region
////////////////////////////////////////////////////////////////////////////

interface region_ctrl_if;
   import blink_pkg::*;

   // high while the region outputs must not be trusted
   logic     freeze;
   // one-cycle load strobe
   logic     load;
   // persona code, valid with load
   persona_e persona;
   // one-cycle answer, one cycle after load
   logic     loaded;

   modport ctrl (
      output freeze,
      output load,
      output persona,
      input  loaded
   );

   modport region (
      input  load,
      input  persona,
      output loaded
   );

   // the LED driver only looks at the freeze
   modport monitor (
      input  freeze
   );

endinterface

// File: src/blink_pkg.sv
////////////////////////////////////////////////////////////////////////////
// blink package
// widths, counter taps, freeze settle time and the enums shared by the
// LED blinker and its reconfiguration controller
////////////////////////////////////////////////////////////////////////////

package blink_pkg;

   ////////////////////////////////////////////////////////////////////////
   // counter and taps
   ////////////////////////////////////////////////////////////////////////

   // free-running counter width
   localparam int unsigned COUNT_WIDTH = 32;
   // led_zero tap, kept low so the LEDs move in a short simulation
   localparam int unsigned COUNTER_TAP = 6;
   // led_one runs at half the rate of led_zero
   localparam int unsigned LED_ONE_TAP = COUNTER_TAP + 1;

   ////////////////////////////////////////////////////////////////////////
   // reconfiguration timing
   ////////////////////////////////////////////////////////////////////////

   // cycles the freeze is held before the persona load
   localparam int unsigned FREEZE_SETTLE = 8;
   // must hold FREEZE_SETTLE - 1
   localparam int unsigned SETTLE_WIDTH = 4;

   // persona codes, code 3 is left undefined on purpose
   typedef enum logic [1:0] {
      PERSONA_BLINK = 2'd0,
      PERSONA_CHASE = 2'd1,
      PERSONA_DARK  = 2'd2
   } persona_e;

   // controller states
   typedef enum logic [2:0] {
      PR_IDLE,
      PR_FREEZE,
      PR_LOAD,
      PR_THAW,
      PR_ACK
   } pr_state_e;

endpackage
